//--- hdl/cmd_engine_settings.svh
`ifndef CMD_ENGINE_SETTINGS_SVH
`define CMD_ENGINE_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Buffer geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CE_BUF_DEPTH 256   // Words per buffer
`define CE_ADDR_W    8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CE_DATA_W    16    // Data words, commands and registers
`define CE_NUM_REGS  8

`endif

//--- hdl/cmd_engine_pkg.sv
`default_nettype none
`include "cmd_engine_settings.svh"

package cmd_engine_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [7:0] {
		OP_LOAD = 8'h10,
		OP_ADD  = 8'h20,
		OP_SHL  = 8'h28,
		OP_JMP  = 8'h30,
		OP_OUT  = 8'h40,
		OP_HALT = 8'hFF
	} opcode_e;

	// Command word, register view
	typedef struct packed {
		logic [7:0] opcode;
		logic [2:0] arg1;   // Destination register
		logic [4:0] arg2;   // Source reg in [2:0], or shift amount
	} cmd_reg_t;

	// Command word, immediate view
	typedef struct packed {
		logic [7:0] opcode;
		logic [7:0] imm;    // Jump target
	} cmd_imm_t;

	typedef union packed {
		cmd_reg_t rf;
		cmd_imm_t im;
	} cmd_word_u;

	// Host side write into either buffer
	typedef struct packed {
		logic                  en;
		logic                  sel;   // 0 cmd buffer, 1 data buffer
		logic [`CE_ADDR_W-1:0] addr;
		logic [`CE_DATA_W-1:0] data;
	} host_wr_t;

	// Split command as held by the controller
	typedef struct packed {
		opcode_e    op;
		logic [2:0] arg1;
		logic [4:0] arg2;
	} dec_cmd_t;

endpackage

`default_nettype wire

//--- hdl/cmd_buffer.sv
`timescale 1ns/1ns
`default_nettype none
`include "cmd_engine_settings.svh"

module cmd_buffer
	import cmd_engine_pkg::*;
(
	input  wire                  clk,
	input  wire                  rst,
	input  wire host_wr_t        host_wr,
	input  wire                  rd_en,
	input  wire [`CE_ADDR_W-1:0] rd_addr,
	output cmd_word_u            rd_data
);

	logic [`CE_DATA_W-1:0] mem [`CE_BUF_DEPTH];

	// Host write port, sel low picks this buffer
	always_ff @(posedge clk)
	begin
		if (host_wr.en && !host_wr.sel)
			mem[host_wr.addr] <= host_wr.data;
	end

	// Read port, output holds between fetches
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			rd_data <= '0;
		else if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- hdl/data_buffer.sv
`timescale 1ns/1ns
`default_nettype none
`include "cmd_engine_settings.svh"

module data_buffer
	import cmd_engine_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst,
	input  wire host_wr_t         host_wr,
	input  wire                   rd_en,
	input  wire [`CE_ADDR_W-1:0]  rd_addr,
	output logic [`CE_DATA_W-1:0] rd_data
);

	logic [`CE_DATA_W-1:0] mem [`CE_BUF_DEPTH];

	always_ff @(posedge clk)
	begin
		if (host_wr.en && host_wr.sel)   // Data side
			mem[host_wr.addr] <= host_wr.data;
	end

	// Registered read, only on LOAD
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			rd_data <= '0;
		else if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- hdl/cmd_fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "cmd_engine_settings.svh"

module cmd_fetch_ctrl
	import cmd_engine_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   start,
	input  wire cmd_word_u        cmd_word,
	output logic                  cmd_rd_en,
	output logic [`CE_ADDR_W-1:0] cmd_addr,
	output logic                  data_rd_en,
	output logic [`CE_ADDR_W-1:0] data_addr,
	output dec_cmd_t              dec,
	output logic                  wb_en,
	output logic                  out_en,
	output logic                  busy,
	output logic                  done,
	output logic                  err
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_SPLIT,
		S_EXEC,
		S_LOAD_WB
	} state_e;

	state_e                state;
	state_e                state_nxt;
	logic [`CE_ADDR_W-1:0] cmd_ptr;
	logic [`CE_ADDR_W-1:0] data_ptr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		state_nxt = state;
		case (state)
			S_IDLE:    if (start) state_nxt = S_FETCH;
			S_FETCH:   state_nxt = S_SPLIT;
			S_SPLIT:   state_nxt = S_EXEC;
			S_EXEC:
			begin
				if (dec.op == OP_LOAD)
					state_nxt = S_LOAD_WB;   // Wait for the data word
				else if (dec.op == OP_HALT)
					state_nxt = S_IDLE;
				else
					state_nxt = S_FETCH;
			end
			S_LOAD_WB: state_nxt = S_FETCH;
			default:   state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state    <= S_IDLE;
			cmd_ptr  <= '0;
			data_ptr <= '0;
			dec      <= '{op: OP_HALT, arg1: '0, arg2: '0};
			err      <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			case (state)
				S_IDLE:
				begin
					if (start)   // New run from address 0
					begin
						cmd_ptr  <= '0;
						data_ptr <= '0;
						err      <= 1'b0;
					end
				end
				S_FETCH: cmd_ptr <= cmd_ptr + 1'b1;
				S_SPLIT:
				begin
					dec.op   <= opcode_e'(cmd_word.rf.opcode);
					dec.arg1 <= cmd_word.rf.arg1;
					dec.arg2 <= cmd_word.rf.arg2;
				end
				S_EXEC:
				begin
					case (dec.op)
						OP_LOAD: data_ptr <= data_ptr + 1'b1;
						// Buffer output still holds the JMP word here
						OP_JMP:  cmd_ptr <= cmd_word.im.imm;
						OP_ADD, OP_SHL, OP_OUT, OP_HALT: ;
						default: err <= 1'b1;   // Unknown, skipped
					endcase
				end
				default: ;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		cmd_rd_en  = (state == S_FETCH);
		cmd_addr   = cmd_ptr;
		data_addr  = data_ptr;
		data_rd_en = (state == S_EXEC) && (dec.op == OP_LOAD);
		wb_en      = ((state == S_EXEC) && (dec.op == OP_ADD || dec.op == OP_SHL))
			|| (state == S_LOAD_WB);
		out_en     = (state == S_EXEC) && (dec.op == OP_OUT);
		done       = (state == S_EXEC) && (dec.op == OP_HALT);
		busy       = (state != S_IDLE);
	end

endmodule

`default_nettype wire

//--- hdl/reg_bank.sv
`timescale 1ns/1ns
`default_nettype none
`include "cmd_engine_settings.svh"

module reg_bank
(
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   wr_en,
	input  wire [2:0]             wr_addr,
	input  wire [`CE_DATA_W-1:0]  wr_data,
	input  wire [2:0]             ra_addr,
	output logic [`CE_DATA_W-1:0] ra_data,
	input  wire [2:0]             rb_addr,
	output logic [`CE_DATA_W-1:0] rb_data
);

	logic [`CE_DATA_W-1:0] regs [`CE_NUM_REGS];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < `CE_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Two read ports, no bypass
	always_comb
	begin
		ra_data = regs[ra_addr];
		rb_data = regs[rb_addr];
	end

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "cmd_engine_settings.svh"

module exec_unit
	import cmd_engine_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst,
	input  wire dec_cmd_t         dec,
	input  wire [`CE_DATA_W-1:0]  rd_data,
	input  wire [`CE_DATA_W-1:0]  rs_data,
	input  wire [`CE_DATA_W-1:0]  data_word,
	input  wire                   out_en,
	output logic [`CE_DATA_W-1:0] wr_data,
	output logic                  result_valid,
	output logic [`CE_DATA_W-1:0] result_data
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write-back value
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		case (dec.op)
			OP_LOAD: wr_data = data_word;
			OP_ADD:  wr_data = rd_data + rs_data;   // Wraps at 16 bits
			OP_SHL:
			begin
				if (dec.arg2 >= 5'd16)
					wr_data = '0;
				else
					wr_data = rd_data << dec.arg2[3:0];
			end
			default: wr_data = rd_data;
		endcase
	end

	// Result port, one cycle after EXEC of OUT
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			result_valid <= 1'b0;
		else
			result_valid <= out_en;
	end

	always_ff @(posedge clk)
	begin
		if (out_en)
			result_data <= rd_data;
	end

endmodule

`default_nettype wire

//--- hdl/cmd_engine.sv
`timescale 1ns/1ns
`default_nettype none
`include "cmd_engine_settings.svh"

module cmd_engine
	import cmd_engine_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst,
	input  wire host_wr_t         host_wr,
	input  wire                   start,
	output logic                  result_valid,
	output logic [`CE_DATA_W-1:0] result_data,
	output logic                  done,
	output logic                  busy,
	output logic                  err
);

	cmd_word_u             cmd_word;
	logic [`CE_DATA_W-1:0] data_word;
	logic                  cmd_rd_en;
	logic [`CE_ADDR_W-1:0] cmd_addr;
	logic                  data_rd_en;
	logic [`CE_ADDR_W-1:0] data_addr;
	dec_cmd_t              dec;
	logic                  wb_en;
	logic                  out_en;
	logic [`CE_DATA_W-1:0] rs_data;
	logic [`CE_DATA_W-1:0] rd_data;
	logic [`CE_DATA_W-1:0] wr_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Buffers, both see every host write
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	cmd_buffer u_cmd_buf (
		.clk(clk), .rst(rst), .host_wr(host_wr),
		.rd_en(cmd_rd_en), .rd_addr(cmd_addr), .rd_data(cmd_word)
	);

	data_buffer u_data_buf (
		.clk(clk), .rst(rst), .host_wr(host_wr),
		.rd_en(data_rd_en), .rd_addr(data_addr), .rd_data(data_word)
	);

	cmd_fetch_ctrl u_ctrl (
		.clk(clk), .rst(rst), .start(start), .cmd_word(cmd_word),
		.cmd_rd_en(cmd_rd_en), .cmd_addr(cmd_addr),
		.data_rd_en(data_rd_en), .data_addr(data_addr),
		.dec(dec), .wb_en(wb_en), .out_en(out_en),
		.busy(busy), .done(done), .err(err)
	);

	// Port a is the source, port b the destination
	reg_bank u_regs (
		.clk(clk), .rst(rst),
		.wr_en(wb_en), .wr_addr(dec.arg1), .wr_data(wr_data),
		.ra_addr(dec.arg2[2:0]), .ra_data(rs_data),
		.rb_addr(dec.arg1), .rb_data(rd_data)
	);

	exec_unit u_exec (
		.clk(clk), .rst(rst), .dec(dec),
		.rd_data(rd_data), .rs_data(rs_data), .data_word(data_word),
		.out_en(out_en), .wr_data(wr_data),
		.result_valid(result_valid), .result_data(result_data)
	);

endmodule

`default_nettype wire

//--- tb/cmd_engine_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_engine_assertions
(
	input wire clk,
	input wire rst,
	input wire busy,
	input wire done,
	input wire wb_en,
	input wire out_en,
	input wire cmd_rd_en
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Controller protocol
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	done_single_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Strobes only inside a run
	strobe_when_busy: assert property (@(posedge clk) disable iff (!rst)
		(wb_en || out_en) |-> busy)
		else $error("write-back or output strobe while the engine was idle");

	fetch_not_back_to_back: assert property (@(posedge clk) disable iff (!rst)
		cmd_rd_en |=> !cmd_rd_en)
		else $error("command read enable high in two consecutive cycles");

endmodule

bind cmd_fetch_ctrl cmd_engine_assertions u_assert (
	.clk(clk), .rst(rst), .busy(busy), .done(done),
	.wb_en(wb_en), .out_en(out_en), .cmd_rd_en(cmd_rd_en)
);

`default_nettype wire

//--- tb/cmd_engine_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "cmd_engine_settings.svh"

module cmd_engine_tb
	import cmd_engine_pkg::*;
();

	localparam int TOTAL_CMDS     = 49;   // Commands issued over all runs
	localparam int TIMEOUT_CYCLES = 4 * TOTAL_CMDS + 200;

	logic                  clk;
	logic                  rst;
	logic                  start;
	host_wr_t              host_wr;
	logic                  result_valid;
	logic [`CE_DATA_W-1:0] result_data;
	logic                  done;
	logic                  busy;
	logic                  err;

	logic [31:0]           rng_state;
	logic [`CE_DATA_W-1:0] prog_img [`CE_BUF_DEPTH];   // Mirror of the command buffer
	logic [`CE_DATA_W-1:0] data_img [`CE_BUF_DEPTH];
	logic [`CE_DATA_W-1:0] model_regs [`CE_NUM_REGS];
	logic [`CE_DATA_W-1:0] exp_q [$];
	logic [`CE_DATA_W-1:0] exp_all_q [$];   // Every OUT value of the last modelled run
	logic [`CE_DATA_W-1:0] got_q [$];
	logic [`CE_DATA_W-1:0] mon_exp;
	logic                  exp_err;
	logic [`CE_ADDR_W-1:0] cmd_wr_ptr;
	logic [`CE_ADDR_W-1:0] data_wr_ptr;
	int                    error_count;
	int                    check_count;
	int                    cycle_count = 0;

	cmd_engine u_dut (
		.clk(clk), .rst(rst), .host_wr(host_wr), .start(start),
		.result_valid(result_valid), .result_data(result_data),
		.done(done), .busy(busy), .err(err)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] random_word();
		rng_state = xorshift32(rng_state);
		return rng_state[15:0];
	endfunction

	function automatic logic [15:0] reg_cmd(input logic [7:0] op, input logic [2:0] rd,
		input logic [4:0] rs);
		return {op, rd, rs};
	endfunction

	function automatic logic [15:0] imm_cmd(input logic [7:0] op, input logic [7:0] imm);
		return {op, imm};
	endfunction

	task automatic report_failure(input string msg);
		check_count++;
		error_count++;
		$display("%s", msg);
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			error_count++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count++;
		assert (got === exp)
		else
		begin
			error_count++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic host_write(input logic sel, input logic [7:0] addr, input logic [15:0] data);
		@(posedge clk);
		#1;
		host_wr.en   = 1'b1;
		host_wr.sel  = sel;
		host_wr.addr = addr;
		host_wr.data = data;
	endtask

	task automatic begin_program();
		cmd_wr_ptr  = '0;
		data_wr_ptr = '0;
	endtask

	task automatic put_cmd(input logic [15:0] w);
		host_write(1'b0, cmd_wr_ptr, w);
		prog_img[cmd_wr_ptr] = w;
		cmd_wr_ptr = cmd_wr_ptr + 8'd1;
	endtask

	task automatic put_data(input logic [15:0] w);
		host_write(1'b1, data_wr_ptr, w);
		data_img[data_wr_ptr] = w;
		data_wr_ptr = data_wr_ptr + 8'd1;
	endtask

	// Runs the program image over the model registers, queues OUT values
	task automatic run_model();
		logic [7:0] pc;
		logic [7:0] dp;
		logic [15:0] w;
		logic [2:0] a1;
		logic [4:0] a2;
		bit running;
		int steps;
		pc = 8'd0;
		dp = 8'd0;
		exp_err = 1'b0;
		exp_q.delete();
		exp_all_q.delete();
		running = 1'b1;
		steps = 0;
		while (running && steps < `CE_BUF_DEPTH)
		begin
			w  = prog_img[pc];
			a1 = w[7:5];
			a2 = w[4:0];
			pc = pc + 8'd1;
			steps++;
			case (w[15:8])
				OP_LOAD:
				begin
					model_regs[a1] = data_img[dp];
					dp = dp + 8'd1;
				end
				OP_ADD:  model_regs[a1] = model_regs[a1] + model_regs[a2[2:0]];
				OP_SHL:  model_regs[a1] = model_regs[a1] << a2;   // Zeros shift in
				OP_JMP:  pc = w[7:0];
				OP_OUT:
				begin
					exp_q.push_back(model_regs[a1]);
					exp_all_q.push_back(model_regs[a1]);
				end
				OP_HALT: running = 1'b0;
				default: exp_err = 1'b1;
			endcase
		end
	endtask

	task automatic run_program();
		@(posedge clk);
		#1 host_wr = '0;
		run_model();
		got_q.delete();
		@(posedge clk);
		#1 start = 1'b1;
		@(posedge clk);
		#1 start = 1'b0;
		@(negedge clk);
		check_bit("err", err, 1'b0);   // Cleared by start
		check_bit("busy", busy, 1'b1);
		while (!done)
			@(negedge clk);
		@(negedge clk);
		check_bit("busy", busy, 1'b0);
		check_bit("err", err, exp_err);
		if (exp_q.size() != 0)
			report_failure("run ended before all expected outputs appeared");
	endtask

	// Result monitor, sampled away from the active edge
	always @(negedge clk)
	begin
		if (rst && result_valid)
		begin
			got_q.push_back(result_data);
			if (exp_q.size() == 0)
			begin
				report_failure("result_valid pulsed with no output expected");
			end
			else
			begin
				mon_exp = exp_q.pop_front();
				check_value("result_data", result_data, mon_exp);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run still going after %0d cycles", cycle_count);
			$display("checks: %0d, errors: %0d", check_count, error_count + 1);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic test_reset_state();
		@(negedge clk);
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		check_bit("err", err, 1'b0);
		check_bit("result_valid", result_valid, 1'b0);
	endtask

	task automatic test_add_sum();
		begin_program();
		put_data(random_word() | 16'h8000);   // Both MSBs set so the sum wraps
		put_data(random_word() | 16'h8000);
		put_cmd(reg_cmd(OP_LOAD, 3'd0, 5'd0));
		put_cmd(reg_cmd(OP_LOAD, 3'd1, 5'd0));
		put_cmd(reg_cmd(OP_ADD, 3'd0, 5'd1));
		put_cmd(reg_cmd(OP_OUT, 3'd0, 5'd0));
		put_cmd(imm_cmd(OP_HALT, 8'h00));
		run_program();
	endtask

	task automatic test_shift_amounts();
		logic [4:0] amts [4];
		amts = '{5'd0, 5'd5, 5'd15, 5'd17};
		begin_program();
		for (int i = 0; i < 4; i++)
		begin
			put_data(random_word());
			put_cmd(reg_cmd(OP_LOAD, 3'(i + 1), 5'd0));
			put_cmd(reg_cmd(OP_SHL, 3'(i + 1), amts[i]));
			put_cmd(reg_cmd(OP_OUT, 3'(i + 1), 5'd0));
		end
		put_cmd(imm_cmd(OP_HALT, 8'h00));
		run_program();
	endtask

	task automatic test_jump_skip();
		begin_program();
		put_data(random_word());
		put_data(random_word());
		put_cmd(reg_cmd(OP_LOAD, 3'd0, 5'd0));
		put_cmd(reg_cmd(OP_OUT, 3'd0, 5'd0));
		put_cmd(imm_cmd(OP_JMP, 8'd6));
		put_cmd(reg_cmd(OP_OUT, 3'd0, 5'd0));    // Skipped block
		put_cmd(reg_cmd(OP_LOAD, 3'd1, 5'd0));
		put_cmd(reg_cmd(OP_OUT, 3'd1, 5'd0));
		put_cmd(reg_cmd(OP_LOAD, 3'd2, 5'd0));   // Jump target
		put_cmd(reg_cmd(OP_OUT, 3'd2, 5'd0));
		put_cmd(reg_cmd(OP_ADD, 3'd2, 5'd0));
		put_cmd(reg_cmd(OP_OUT, 3'd2, 5'd0));
		put_cmd(imm_cmd(OP_HALT, 8'h00));
		run_program();
		check_value("output count", 16'(got_q.size()), 16'd3);
	endtask

	task automatic test_bad_opcode();
		begin_program();
		put_data(random_word());
		put_cmd(reg_cmd(OP_LOAD, 3'd5, 5'd0));
		put_cmd(reg_cmd(8'h55, 3'd2, 5'd7));
		put_cmd(reg_cmd(OP_OUT, 3'd5, 5'd0));
		put_cmd(reg_cmd(OP_SHL, 3'd5, 5'd1));
		put_cmd(reg_cmd(OP_OUT, 3'd5, 5'd0));
		put_cmd(imm_cmd(OP_HALT, 8'h00));
		run_program();
	endtask

	task automatic test_rerun();
		logic [15:0] first_q [$];
		begin_program();
		put_data(random_word());
		put_data(random_word());
		put_cmd(reg_cmd(OP_LOAD, 3'd3, 5'd0));
		put_cmd(reg_cmd(OP_LOAD, 3'd4, 5'd0));
		put_cmd(reg_cmd(OP_ADD, 3'd3, 5'd4));
		put_cmd(reg_cmd(OP_OUT, 3'd3, 5'd0));
		put_cmd(reg_cmd(OP_SHL, 3'd4, 5'd3));
		put_cmd(reg_cmd(OP_OUT, 3'd4, 5'd0));
		put_cmd(imm_cmd(OP_HALT, 8'h00));
		run_program();
		first_q = exp_all_q;   // Model outputs of the first run
		run_program();   // Same buffers, pointers restart at 0
		check_value("rerun output count", 16'(got_q.size()), 16'(first_q.size()));
		for (int i = 0; i < first_q.size() && i < got_q.size(); i++)
			check_value("rerun result_data", got_q[i], first_q[i]);
	endtask

	initial
	begin
		rng_state   = 32'h0fb8d060;
		error_count = 0;
		check_count = 0;
		for (int i = 0; i < `CE_NUM_REGS; i++)
			model_regs[i] = '0;
		rst     = 1'b0;
		start   = 1'b0;
		host_wr = '0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b1;
		test_reset_state();
		test_add_sum();
		test_shift_amounts();
		test_jump_skip();
		test_bad_opcode();
		test_rerun();
		repeat (2) @(posedge clk);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- cmd_engine.f
+incdir+hdl
hdl/cmd_engine_pkg.sv
hdl/cmd_buffer.sv
hdl/data_buffer.sv
hdl/cmd_fetch_ctrl.sv
hdl/reg_bank.sv
hdl/exec_unit.sv
hdl/cmd_engine.sv
tb/cmd_engine_assertions.sv
tb/cmd_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cmd_engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cmd_engine.f --top-module cmd_engine_tb

status=0
out=$(./obj_dir/Vcmd_engine_tb 2>&1) || status=$?
printf '%s\n' "$out"

[ "$status" -eq 0 ] || exit 1
if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1
